/* all.f */
design/ipif_timer_pkg.sv
design/ipif_ce_decode.sv
design/ipif_param_bank.sv
design/event_timer.sv
design/timer_channel.sv
design/ipif_read_merge.sv
design/ipif_timer_top.sv
bench/ipif_timer_assert.sv
bench/tb_ipif_timer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the timer bank testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f all.f --top-module tb_ipif_timer -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_ipif_timer
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished"
exit 0

/* bench/tb_ipif_timer.sv */
`timescale 1ns/1ns

module tb_ipif_timer;
	import ipif_timer_pkg::*;

	localparam int OP_WR       = 0;
	localparam int OP_RD       = 1;
	localparam int OP_RD_TICKS = 2;
	localparam int OP_WAIT     = 3;

	logic              clk = 1'b0;
	logic              IPIF_bus2ip_resetn;
	logic [ADDR_W-1:0] bus_addr;
	logic              bus_wr;
	logic              bus_rd;
	logic [DATA_W-1:0] bus_wdata;
	logic [DATA_W-1:0] bus_rdata;
	logic              bus_rdack;
	logic              bus_wrack;
	logic              bus_error;
	logic [N_CHAN-1:0] tick;

	// Stimulus table, one entry per row in each queue
	string             row_name[$];
	int                row_op[$];
	logic [ADDR_W-1:0] row_addr[$];
	logic [DATA_W-1:0] row_wdata[$];
	logic [DATA_W-1:0] row_exp[$];

	// Reference state of each channel, kept by the tick monitor
	bit    exp_en[N_CHAN];
	int    exp_per[N_CHAN];
	bit    seen[N_CHAN];
	int    last_tick[N_CHAN];
	int    tick_total[N_CHAN];
	int    cycle = 0;
	int    limit = 0;
	int    seed = 32'h402c30c8;
	string cur_name = "reset";

	ipif_timer_top u_ipif_timer_top (
		.clk                (clk),
		.IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
		.bus_addr           (bus_addr),
		.bus_wr             (bus_wr),
		.bus_rd             (bus_rd),
		.bus_wdata          (bus_wdata),
		.bus_rdata          (bus_rdata),
		.bus_rdack          (bus_rdack),
		.bus_wrack          (bus_wrack),
		.bus_error          (bus_error),
		.tick               (tick)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (exp !== act) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic add_row(input string name, input int op, input int addr,
			input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(ADDR_W'(addr));
		row_wdata.push_back(wdata);
		row_exp.push_back(exp);
	endtask

	// Control write as the channel should see it
	task automatic update_model(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
		int c;
		c = int'(addr) / N_REG;
		if (addr < ADDR_W'(N_CHAN * N_REG) && int'(addr) % N_REG == REG_CTRL) begin
			if (wdata[CTRL_CLR_BIT] || (wdata[CTRL_EN_BIT] && !exp_en[c])) begin
				seen[c] = 1'b0;
			end
			if (wdata[CTRL_CLR_BIT]) begin
				tick_total[c] = 0;
			end
			exp_en[c]  = wdata[CTRL_EN_BIT];
			exp_per[c] = int'(wdata[CTRL_PER_LSB +: CNT_W]);
		end
	endtask

	task automatic bus_access(input string name, input bit is_wr, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		logic exp_err;
		exp_err = (addr >= ADDR_W'(N_CHAN * N_REG));
		@(posedge clk);
		bus_addr  <= addr;
		bus_wdata <= wdata;
		bus_wr    <= is_wr;
		bus_rd    <= ~is_wr;
		@(negedge clk);
		check_value({name, " early ack"}, '0, DATA_W'({bus_wrack, bus_rdack}));
		@(posedge clk);
		bus_wr <= 1'b0;
		bus_rd <= 1'b0;
		@(negedge clk);
		check_value({name, " wrack"}, DATA_W'(is_wr), DATA_W'(bus_wrack));
		check_value({name, " rdack"}, DATA_W'(!is_wr), DATA_W'(bus_rdack));
		check_value({name, " bus_error"}, DATA_W'(exp_err), DATA_W'(bus_error));
		rdata = bus_rdata;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tick monitor and timeout
	//////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		for (int c = 0; c < N_CHAN; c++) begin
			if (tick[c]) begin
				if (!exp_en[c]) begin
					check_value({cur_name, " tick on disabled channel"}, '0, DATA_W'(1));
				end
				if (seen[c]) begin
					check_value({cur_name, " tick spacing"}, DATA_W'(exp_per[c] + 1),
						DATA_W'(cycle - last_tick[c]));
				end
				seen[c]      = 1'b1;
				last_tick[c] = cycle;
				tick_total[c]++;
			end
		end
		// A strobe in this cycle takes effect from the next one
		if (bus_wr === 1'b1) begin
			update_model(bus_addr, bus_wdata);
		end
	end

	always @(posedge clk) begin
		cycle++;
		if (cycle > limit) begin
			$display("Timeout: run went past %0d cycles", limit);
			$display("=== FAIL ===");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		int                per[N_CHAN];
		logic [DATA_W-1:0] ctrl[N_CHAN];
		logic [DATA_W-1:0] rd;
		int                waits;
		int                n_acc;
		int                c;
		IPIF_bus2ip_resetn <= 1'b0;
		bus_addr           <= '0;
		bus_wr             <= 1'b0;
		bus_rd             <= 1'b0;
		bus_wdata          <= '0;
		for (int a = 0; a < N_CHAN * N_REG; a++) begin
			add_row("reset_defaults", OP_RD, a, '0, '0);
		end
		// Channels 0 to 2 run, channel 3 stays disabled
		for (int i = 0; i < N_CHAN; i++) begin
			per[i]  = 2 + int'($unsigned($random(seed)) % 19);
			ctrl[i] = (DATA_W'(per[i]) << CTRL_PER_LSB) | DATA_W'(i < N_CHAN - 1);
			add_row("write_ctrl", OP_WR, i * N_REG, ctrl[i] | (DATA_W'(1) << CTRL_CLR_BIT), '0);
		end
		for (int i = 0; i < N_CHAN; i++) begin
			add_row("readback_ctrl", OP_RD, i * N_REG, '0, ctrl[i]);
		end
		add_row("tick_spacing", OP_WAIT, 0, 150, '0);
		for (int i = 0; i < 2; i++) begin
			ctrl[i] = ctrl[i] & ~(DATA_W'(1) << CTRL_EN_BIT);
			add_row("tick_count", OP_WR, i * N_REG, ctrl[i], '0);
			add_row("tick_count", OP_RD_TICKS, i * N_REG + REG_STAT, '0, '0);
		end
		ctrl[0] = '0;
		add_row("clear", OP_WR, REG_CTRL, DATA_W'(1) << CTRL_CLR_BIT, '0);
		add_row("clear", OP_RD, REG_STAT, '0, '0);
		add_row("clear", OP_RD, REG_CTRL, '0, '0);
		add_row("clear", OP_WAIT, 0, 40, '0);
		ctrl[2] = ctrl[2] & ~(DATA_W'(1) << CTRL_EN_BIT);
		add_row("clear", OP_WR, 2 * N_REG, ctrl[2], '0);
		add_row("clear", OP_RD_TICKS, 2 * N_REG + REG_STAT, '0, '0);
		add_row("unmapped", OP_WR, 8, 32'hffffffff, '0);
		add_row("unmapped", OP_WR, 255, 32'h5a5a5a5a, '0);
		add_row("unmapped", OP_RD, 9, '0, '0);
		add_row("unmapped", OP_RD, 200, '0, '0);
		for (int i = 0; i < N_CHAN; i++) begin
			add_row("unmapped_readback", OP_RD, i * N_REG, '0, ctrl[i]);
			add_row("unmapped_readback", OP_RD_TICKS, i * N_REG + REG_STAT, '0, '0);
		end
		waits = 0;
		n_acc = 0;
		foreach (row_op[i]) begin
			if (row_op[i] == OP_WAIT) begin
				waits += int'(row_wdata[i]);
			end else begin
				n_acc++;
			end
		end
		limit = waits + 4 * n_acc + 200;

		repeat (4) @(posedge clk);
		IPIF_bus2ip_resetn <= 1'b1;

		foreach (row_op[i]) begin
			cur_name = row_name[i];
			case (row_op[i])
				OP_WAIT: repeat (int'(row_wdata[i])) @(posedge clk);
				OP_WR: bus_access(row_name[i], 1'b1, row_addr[i], row_wdata[i], rd);
				OP_RD: begin
					bus_access(row_name[i], 1'b0, row_addr[i], '0, rd);
					check_value({row_name[i], " rdata"}, row_exp[i], rd);
				end
				default: begin
					bus_access(row_name[i], 1'b0, row_addr[i], '0, rd);
					c = int'(row_addr[i]) / N_REG;
					check_value({row_name[i], " tick count"},
						DATA_W'(tick_total[c]) & 32'h0000ffff, rd >> CNT_W);
				end
			endcase
		end
		repeat (2) @(posedge clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* bench/ipif_timer_assert.sv */
`timescale 1ns/1ns

module ipif_timer_assert (
	input logic                               clk,
	input logic                               IPIF_bus2ip_resetn,
	input logic [ipif_timer_pkg::ADDR_W-1:0]  bus_addr,
	input logic                               bus_wr,
	input logic                               bus_rd,
	input logic                               bus_wrack,
	input logic                               bus_rdack,
	input logic                               bus_error
);
	import ipif_timer_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Strobe to acknowledge
	//////////////////////////////////////////////////////////////////////
	a_wr_ack: assert property (@(posedge clk) disable iff (!IPIF_bus2ip_resetn)
		bus_wr |=> bus_wrack && !bus_rdack)
		else $error("write strobe without its acknowledge one cycle later");

	a_rd_ack: assert property (@(posedge clk) disable iff (!IPIF_bus2ip_resetn)
		bus_rd |=> bus_rdack && !bus_wrack)
		else $error("read strobe without its acknowledge one cycle later");

	// Acknowledges only follow a strobe
	a_wr_cause: assert property (@(posedge clk) disable iff (!IPIF_bus2ip_resetn)
		bus_wrack |-> $past(bus_wr))
		else $error("write acknowledge without a strobe");

	a_rd_cause: assert property (@(posedge clk) disable iff (!IPIF_bus2ip_resetn)
		bus_rdack |-> $past(bus_rd))
		else $error("read acknowledge without a strobe");

	// Error only with the acknowledge of an access beyond the last channel
	a_err_ack: assert property (@(posedge clk) disable iff (!IPIF_bus2ip_resetn)
		bus_error == ((bus_wrack || bus_rdack) &&
			($past(bus_addr) >= ADDR_W'(N_CHAN * N_REG))))
		else $error("bus_error does not match an acknowledged unmapped access");

	a_ack_excl: assert property (@(posedge clk) disable iff (!IPIF_bus2ip_resetn)
		!(bus_wrack && bus_rdack))
		else $error("read and write acknowledge high together");

endmodule

bind ipif_timer_top ipif_timer_assert u_ipif_timer_assert (
	.clk                (clk),
	.IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
	.bus_addr           (bus_addr),
	.bus_wr             (bus_wr),
	.bus_rd             (bus_rd),
	.bus_wrack          (bus_wrack),
	.bus_rdack          (bus_rdack),
	.bus_error          (bus_error)
);

/* design/ipif_timer_top.sv */
`timescale 1ns/1ns

module ipif_timer_top (
	input  logic                               clk,
	input  logic                               IPIF_bus2ip_resetn,
	input  logic [ipif_timer_pkg::ADDR_W-1:0]  bus_addr,
	input  logic                               bus_wr,
	input  logic                               bus_rd,
	input  logic [ipif_timer_pkg::DATA_W-1:0]  bus_wdata,
	output logic [ipif_timer_pkg::DATA_W-1:0]  bus_rdata,
	output logic                               bus_rdack,
	output logic                               bus_wrack,
	output logic                               bus_error,
	output logic [ipif_timer_pkg::N_CHAN-1:0]  tick
);
	import ipif_timer_pkg::*;

	logic [N_CHAN-1:0][N_REG-1:0]  chan_wrce;
	logic [N_CHAN-1:0][N_REG-1:0]  chan_rdce;
	logic                          err_wrack;
	logic                          err_rdack;
	logic [N_CHAN-1:0][DATA_W-1:0] ch_rdata;
	logic [N_CHAN-1:0]             ch_rdack;
	logic [N_CHAN-1:0]             ch_wrack;

	ipif_ce_decode u_ce_decode (
		.clk                (clk),
		.IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
		.bus_addr           (bus_addr),
		.bus_wr             (bus_wr),
		.bus_rd             (bus_rd),
		.chan_wrce          (chan_wrce),
		.chan_rdce          (chan_rdce),
		.err_wrack          (err_wrack),
		.err_rdack          (err_rdack)
	);

	////////////////////////////////////////////////////////////////////
	// Timer channels
	////////////////////////////////////////////////////////////////////
	for (genvar c = 0; c < N_CHAN; c++) begin : g_chan
		timer_channel u_timer_channel (
			.clk                (clk),
			.IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
			.bus_wdata          (bus_wdata),
			.wrce               (chan_wrce[c]),
			.rdce               (chan_rdce[c]),
			.rdata              (ch_rdata[c]),
			.rdack              (ch_rdack[c]),
			.wrack              (ch_wrack[c]),
			.tick               (tick[c])
		);
	end

	ipif_read_merge u_read_merge (
		.ch_rdata  (ch_rdata),
		.ch_rdack  (ch_rdack),
		.ch_wrack  (ch_wrack),
		.err_rdack (err_rdack),
		.err_wrack (err_wrack),
		.bus_rdata (bus_rdata),
		.bus_rdack (bus_rdack),
		.bus_wrack (bus_wrack),
		.bus_error (bus_error)
	);

endmodule

/* design/ipif_read_merge.sv */
`timescale 1ns/1ns

module ipif_read_merge (
	input  logic [ipif_timer_pkg::N_CHAN-1:0][ipif_timer_pkg::DATA_W-1:0] ch_rdata,
	input  logic [ipif_timer_pkg::N_CHAN-1:0]                             ch_rdack,
	input  logic [ipif_timer_pkg::N_CHAN-1:0]                             ch_wrack,
	input  logic                                                          err_rdack,
	input  logic                                                          err_wrack,
	output logic [ipif_timer_pkg::DATA_W-1:0]                             bus_rdata,
	output logic                                                          bus_rdack,
	output logic                                                          bus_wrack,
	output logic                                                          bus_error
);
	import ipif_timer_pkg::*;

	////////////////////////////////////////////////////////////////////
	// Read data select
	////////////////////////////////////////////////////////////////////
	always_comb begin
		// Banks drive their data register even when idle,
		// so mask each one with its own acknowledge
		bus_rdata = ERR_DATA & {DATA_W{err_rdack}};
		for (int c = 0; c < N_CHAN; c++) begin
			bus_rdata = bus_rdata | (ch_rdata[c] & {DATA_W{ch_rdack[c]}});
		end
	end

	// Acknowledges are already registered upstream
	assign bus_rdack = (|ch_rdack) | err_rdack;
	assign bus_wrack = (|ch_wrack) | err_wrack;
	assign bus_error = err_rdack | err_wrack;

endmodule

/* design/timer_channel.sv */
`timescale 1ns/1ns

module timer_channel (
	input  logic                               clk,
	input  logic                               IPIF_bus2ip_resetn,
	input  logic [ipif_timer_pkg::DATA_W-1:0]  bus_wdata,
	input  logic [ipif_timer_pkg::N_REG-1:0]   wrce,
	input  logic [ipif_timer_pkg::N_REG-1:0]   rdce,
	output logic [ipif_timer_pkg::DATA_W-1:0]  rdata,
	output logic                               rdack,
	output logic                               wrack,
	output logic                               tick
);
	import ipif_timer_pkg::*;

	logic [N_REG-1:0][DATA_W-1:0] params_out;
	logic [N_REG-1:0][DATA_W-1:0] readback;
	logic [DATA_W-1:0]            ctrl_word;
	logic [CNT_W-1:0]             counter;
	logic [CNT_W-1:0]             tick_count;

	assign ctrl_word = params_out[REG_CTRL];

	// Control word loops back so the clear bit can self-reset
	assign readback[REG_CTRL] = ctrl_word;
	assign readback[REG_STAT] = {tick_count, counter};

	ipif_param_bank u_param_bank (
		.clk                (clk),
		.IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
		.bus_wdata          (bus_wdata),
		.wrce               (wrce),
		.rdce               (rdce),
		.params_in          (readback),
		.params_out         (params_out),
		.rdata              (rdata),
		.rdack              (rdack),
		.wrack              (wrack)
	);

	event_timer u_event_timer (
		.clk                (clk),
		.IPIF_bus2ip_resetn (IPIF_bus2ip_resetn),
		.enable             (ctrl_word[CTRL_EN_BIT]),
		.clear              (ctrl_word[CTRL_CLR_BIT]),
		.period             (ctrl_word[CTRL_PER_LSB +: CNT_W]),
		.tick               (tick),
		.counter            (counter),
		.tick_count         (tick_count)
	);

endmodule

/* design/event_timer.sv */
`timescale 1ns/1ns

module event_timer (
	input  logic                               clk,
	input  logic                               IPIF_bus2ip_resetn,
	input  logic                               enable,
	input  logic                               clear,
	input  logic [ipif_timer_pkg::CNT_W-1:0]   period,
	output logic                               tick,
	output logic [ipif_timer_pkg::CNT_W-1:0]   counter,
	output logic [ipif_timer_pkg::CNT_W-1:0]   tick_count
);

	logic at_period;

	assign at_period = (counter == period);

	// Tick lasts the single cycle spent at the period value
	assign tick = enable & ~clear & at_period;

	////////////////////////////////////////////////////////////////////
	// Period counter and tick counter
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge IPIF_bus2ip_resetn) begin
		if (!IPIF_bus2ip_resetn) begin
			counter    <= '0;
			tick_count <= '0;
		end else if (clear) begin
			// Clear beats enable
			counter    <= '0;
			tick_count <= '0;
		end else if (enable) begin
			if (at_period) begin
				counter    <= '0;
				tick_count <= tick_count + 1'b1;
			end else begin
				counter <= counter + 1'b1;
			end
		end
	end

	// Counts hold while disabled

endmodule

/* design/ipif_param_bank.sv */
`timescale 1ns/1ns

module ipif_param_bank (
	input  logic                                 clk,
	input  logic                                 IPIF_bus2ip_resetn,
	input  logic [ipif_timer_pkg::DATA_W-1:0]    bus_wdata,
	input  logic [ipif_timer_pkg::N_REG-1:0]     wrce,
	input  logic [ipif_timer_pkg::N_REG-1:0]     rdce,
	input  logic [ipif_timer_pkg::PARAM_W-1:0]   params_in,
	output logic [ipif_timer_pkg::PARAM_W-1:0]   params_out,
	output logic [ipif_timer_pkg::DATA_W-1:0]    rdata,
	output logic                                 rdack,
	output logic                                 wrack
);
	import ipif_timer_pkg::*;

	logic [N_REG-1:0][DATA_W-1:0] regs;
	logic [N_REG-1:0][DATA_W-1:0] regs_next;
	logic [N_REG-1:0][DATA_W-1:0] in_words;
	logic [N_REG-1:0][DATA_W-1:0] def_words;
	logic [N_REG-1:0][DATA_W-1:0] sr_words;
	logic [REG_IDX_W-1:0]         rd_sel;

	assign in_words   = params_in;
	assign def_words  = PARAM_DEFAULTS;
	assign sr_words   = PARAM_SELF_RESET;
	assign params_out = regs;

	////////////////////////////////////////////////////////////////////
	// Register update with self-reset
	////////////////////////////////////////////////////////////////////
	always_comb begin
		logic [DATA_W-1:0] sr_cond;
		logic [DATA_W-1:0] held;
		for (int i = 0; i < N_REG; i++) begin
			// Masked bits whose readback left the default go back to it
			sr_cond = sr_words[i] & (in_words[i] ^ def_words[i]);
			held = (def_words[i] & sr_cond) | (regs[i] & ~sr_cond);
			regs_next[i] = wrce[i] ? bus_wdata : held;
		end
	end

	always_ff @(posedge clk or negedge IPIF_bus2ip_resetn) begin
		if (!IPIF_bus2ip_resetn) begin
			regs  <= PARAM_DEFAULTS;
			wrack <= 1'b0;
		end else begin
			regs  <= regs_next;
			wrack <= |wrce;
		end
	end

	////////////////////////////////////////////////////////////////////
	// One-hot readback
	////////////////////////////////////////////////////////////////////
	always_comb begin
		rd_sel = '0;
		// Highest set chip-enable wins
		for (int i = 0; i < N_REG; i++) begin
			if (rdce[i]) begin
				rd_sel = REG_IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge IPIF_bus2ip_resetn) begin
		if (!IPIF_bus2ip_resetn) begin
			rdack <= 1'b0;
		end else begin
			rdack <= |rdce;
		end
	end

	// Data register follows the selected word every cycle
	always_ff @(posedge clk) begin
		rdata <= in_words[rd_sel];
	end

endmodule

/* design/ipif_ce_decode.sv */
`timescale 1ns/1ns

module ipif_ce_decode (
	input  logic                                clk,
	input  logic                                IPIF_bus2ip_resetn,
	input  logic [ipif_timer_pkg::ADDR_W-1:0]   bus_addr,
	input  logic                                bus_wr,
	input  logic                                bus_rd,
	output logic [ipif_timer_pkg::N_CHAN-1:0][ipif_timer_pkg::N_REG-1:0] chan_wrce,
	output logic [ipif_timer_pkg::N_CHAN-1:0][ipif_timer_pkg::N_REG-1:0] chan_rdce,
	output logic                                err_wrack,
	output logic                                err_rdack
);
	import ipif_timer_pkg::*;

	logic [ADDR_W-1:0] chan_idx;
	logic [ADDR_W-1:0] reg_idx;
	logic              mapped;

	// Word address is channel * N_REG + register
	assign chan_idx = bus_addr / ADDR_W'(N_REG);
	assign reg_idx  = bus_addr % ADDR_W'(N_REG);
	assign mapped   = bus_addr < ADDR_W'(N_CHAN * N_REG);

	always_comb begin
		logic hit;
		for (int c = 0; c < N_CHAN; c++) begin
			for (int r = 0; r < N_REG; r++) begin
				hit = mapped && (chan_idx == ADDR_W'(c)) && (reg_idx == ADDR_W'(r));
				chan_wrce[c][r] = bus_wr & hit;
				chan_rdce[c][r] = bus_rd & hit;
			end
		end
	end

	// Unmapped accesses are answered here, one cycle after the strobe
	always_ff @(posedge clk or negedge IPIF_bus2ip_resetn) begin
		if (!IPIF_bus2ip_resetn) begin
			err_wrack <= 1'b0;
			err_rdack <= 1'b0;
		end else begin
			err_wrack <= bus_wr & ~mapped;
			err_rdack <= bus_rd & ~mapped;
		end
	end

endmodule

/* design/ipif_timer_pkg.sv */
package ipif_timer_pkg;

	////////////////////////////////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////////////////////////////////
	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;

	// Four channels of two registers each
	localparam int N_CHAN    = 4;
	localparam int N_REG     = 2;
	localparam int REG_IDX_W = $clog2(N_REG);
	localparam int REG_CTRL  = 0;
	localparam int REG_STAT  = 1;

	////////////////////////////////////////////////////////////////////
	// Control word layout
	////////////////////////////////////////////////////////////////////
	localparam int CTRL_EN_BIT  = 0;
	localparam int CTRL_CLR_BIT = 1;
	localparam int CTRL_PER_LSB = 16;
	localparam int CNT_W        = 16;

	// Per-channel register payload
	localparam int PARAM_W = N_REG * DATA_W;
	localparam logic [PARAM_W-1:0] PARAM_DEFAULTS = '0;
	localparam logic [PARAM_W-1:0] PARAM_SELF_RESET =
		PARAM_W'(1) << (REG_CTRL * DATA_W + CTRL_CLR_BIT);

	localparam logic [DATA_W-1:0] ERR_DATA = '0;

endpackage
